// File: Makefile
SOURCES := $(shell cat filelist.f)

.PHONY: run clean

run: obj_dir/Vtb_magic
	obj_dir/Vtb_magic | tee sim.log
	@grep -qx "ALL CHECKS PASSED" sim.log || { echo "simulation failed, see sim.log"; exit 1; }

obj_dir/Vtb_magic: filelist.f $(SOURCES) source/magic_rom.hex
	verilator --binary --timing --timescale 1ns/1ps --top-module tb_magic -j 0 -f filelist.f

clean:
	rm -rf obj_dir sim.log

// File: bench/tb_magic.sv
`default_nettype none

module tb_magic;

    timeunit 1ns;
    timeprecision 1ps;

    import magic_pkg::*;

    localparam int clk_period = 8;
    // the watchdog allows twice the sum of these per-test cycle budgets
    localparam int reset_cycles    = 20;
    localparam int rom_cycles      = 60;
    localparam int config_cycles   = 50;
    localparam int exit_cycles     = 16;
    localparam int nmi_cycles      = 70;
    localparam int reentry_cycles  = 16;
    localparam int watchdog_cycles = 2 * (reset_cycles + rom_cycles + config_cycles
                                          + exit_cycles + nmi_cycles + reentry_cycles);

    logic       clk28;
    logic       rst_n;
    cpu_bus_t   bus;
    logic       n_int;
    logic       n_int_next;
    logic       magic_button;
    logic       pause_button;
    logic       sd_cd;
    logic       div_automap;
    logic [7:0] d_out;
    logic       d_out_active;
    logic       n_nmi;
    logic       magic_mode;
    logic       magic_map;
    magic_cfg_t cfg;

    logic [7:0] rom_model [32];
    magic_cfg_t cfg_expected;
    integer     seed;
    int         errors;
    int         checks;

    magic_top DUT (
        .clk28        (clk28),
        .rst_n        (rst_n),
        .bus          (bus),
        .n_int        (n_int),
        .n_int_next   (n_int_next),
        .magic_button (magic_button),
        .pause_button (pause_button),
        .sd_cd        (sd_cd),
        .div_automap  (div_automap),
        .d_out        (d_out),
        .d_out_active (d_out_active),
        .n_nmi        (n_nmi),
        .magic_mode   (magic_mode),
        .magic_map    (magic_map),
        .cfg          (cfg)
    );

    initial begin
        clk28 = 1'b0;
        forever begin
            #(clk_period / 2) clk28 = ~clk28;
        end
    end

    task automatic check_byte(input string name, input logic [7:0] got,
                              input logic [7:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error: %s = %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error: %s = %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_cfg(input magic_cfg_t got, input magic_cfg_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error: cfg = %h, expected %h at %0t", got, exp, $time);
        end
    endtask

    task automatic check_nmi(input logic exp);
        checks++;
        if (n_nmi !== exp) begin
            errors++;
            $display("** Error: n_nmi = %h, expected %h at %0t", n_nmi, exp, $time);
        end
    endtask

    // field order follows cpu_bus_t with the msb first
    function automatic cpu_bus_t make_bus(input logic [15:0] addr, input logic [7:0] data,
                                          input logic mem_en, input logic io_en,
                                          input logic rd_en, input logic wr_en,
                                          input logic m1_en);
        return {addr, data, mem_en, io_en, rd_en, wr_en, m1_en};
    endfunction

    // expected effect of a config port write as the port table gives it
    function automatic magic_cfg_t apply_write(input magic_cfg_t c, input logic [7:0] port,
                                               input logic [7:0] d);
        case (port)
            8'h01: begin
                c.beeper = d[0];
                c.reboot = d[1];
            end
            8'h02: c.machine = machine_t'(d[2:0]);
            8'h03: c.turbo = turbo_t'(d[2:0]);
            8'h04: c.panning = panning_t'(d[1:0]);
            8'h07: c.joy_sinclair = d[0];
            8'h08: c.ay_en = d[0];
            8'h09: c.divmmc_en = divmmc_t'(d[1:0]);
            8'h0a: c.ulaplus_en = d[0];
            8'h0b: begin
                c.covox_en     = d[0];
                c.soundrive_en = d[1];
            end
            default: ;   // other ports keep every field
        endcase
        return c;
    endfunction

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk28);
        end
        #1;
    endtask

    // one bus sample then one idle cycle with the answer taken between the two edges
    task automatic bus_cycle(input cpu_bus_t sample, output logic active,
                             output logic [7:0] data);
        bus = sample;
        @(posedge clk28);
        #1;
        active = d_out_active;
        data   = d_out;
        bus    = '0;
        @(posedge clk28);
        #1;
    endtask

    task automatic mem_read(input logic [15:0] addr, output logic active,
                            output logic [7:0] data);
        bus_cycle(make_bus(addr, 8'h00, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0), active, data);
    endtask

    task automatic m1_fetch(input logic [15:0] addr);
        logic       active;
        logic [7:0] data;
        bus_cycle(make_bus(addr, 8'h00, 1'b1, 1'b0, 1'b1, 1'b0, 1'b1), active, data);
    endtask

    task automatic io_read(input logic [15:0] addr, output logic active,
                           output logic [7:0] data);
        bus_cycle(make_bus(addr, 8'h00, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0), active, data);
    endtask

    task automatic io_write(input logic [15:0] addr, input logic [7:0] wdata);
        logic       active;
        logic [7:0] data;
        bus_cycle(make_bus(addr, wdata, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0), active, data);
    endtask

    task automatic interrupt_edge();
        n_int_next = 1'b0;   // n_int stays high so this sample is the frame edge
        @(posedge clk28);
        #1;
        n_int_next = 1'b1;
    endtask

    task automatic reset_state();
        cfg_expected = '{reboot: 1'b0, beeper: 1'b0, machine: MACHINE_PENT,
                         turbo: TURBO_NONE, panning: PANNING_ABC, joy_sinclair: 1'b0,
                         divmmc_en: DIVMMC_NOOS, ulaplus_en: 1'b1, ay_en: 1'b1,
                         covox_en: 1'b1, soundrive_en: 1'b1};
        check_bit("magic_mode", magic_mode, 1'b1);
        check_bit("magic_map", magic_map, 1'b1);
        check_nmi(1'b1);
        check_bit("d_out_active", d_out_active, 1'b0);
        check_cfg(cfg, cfg_expected);
    endtask

    task automatic rom_and_status_reads();
        logic [15:0] addrs [6];
        logic        active;
        logic [7:0]  data;
        addrs = '{16'h0000, 16'h0005, 16'h001f, 16'h0020, 16'h0066, 16'h3fff};
        foreach (addrs[i]) begin
            mem_read(addrs[i], active, data);
            check_bit("d_out_active", active, 1'b1);
            check_byte("d_out", data, rom_model[addrs[i][4:0]]);   // 32 byte image mirrors
        end
        sd_cd       = 1'b1;
        div_automap = 1'b1;
        idle_cycles(24);
        io_read(16'h00ff, active, data);
        check_bit("d_out_active", active, 1'b1);
        check_byte("d_out", data, 8'b0000_1100);   // div_automap and sd_cd are set here
        mem_read(16'h4000, active, data);
        check_bit("d_out_active", active, 1'b0);
        mem_read(16'hc123, active, data);
        check_bit("d_out_active", active, 1'b0);
    endtask

    task automatic config_writes();
        logic [7:0] ports [9];
        logic [7:0] data;
        ports = '{8'h01, 8'h02, 8'h03, 8'h04, 8'h07, 8'h08, 8'h09, 8'h0a, 8'h0b};
        repeat (2) begin
            foreach (ports[i]) begin
                data = 8'($random(seed));
                io_write({ports[i], 8'hff}, data);
                cfg_expected = apply_write(cfg_expected, ports[i], data);
                check_cfg(cfg, cfg_expected);
            end
        end
        data = 8'($random(seed));
        io_write(16'h05ff, data);
        check_cfg(cfg, cfg_expected);
    endtask

    task automatic service_exit();
        logic       active;
        logic [7:0] data;
        mem_read(16'hf000, active, data);
        check_bit("magic_mode", magic_mode, 1'b0);
        check_bit("magic_map", magic_map, 1'b0);
        mem_read(16'h0010, active, data);
        check_bit("d_out_active", active, 1'b0);
        // these values differ from the current fields so a stray write would show
        io_write(16'h02ff, {5'b00000, ~cfg_expected.machine});
        io_write(16'h0bff, {6'b000000, ~cfg_expected.soundrive_en, ~cfg_expected.covox_en});
        check_cfg(cfg, cfg_expected);
        io_read(16'h00ff, active, data);
        check_bit("d_out_active", active, 1'b0);
    endtask

    task automatic nmi_entry();
        interrupt_edge();   // no button is pressed yet
        check_nmi(1'b1);
        check_bit("magic_mode", magic_mode, 1'b0);
        magic_button = 1'b1;
        idle_cycles(30);
        n_int      = 1'b0;   // with n_int low this sample is no frame edge
        n_int_next = 1'b0;
        @(posedge clk28);
        #1;
        n_int      = 1'b1;
        n_int_next = 1'b1;
        check_nmi(1'b1);
        check_bit("magic_mode", magic_mode, 1'b0);
        interrupt_edge();
        check_nmi(1'b0);
        check_bit("magic_mode", magic_mode, 1'b1);
        check_bit("magic_map", magic_map, 1'b0);
        m1_fetch(16'h0066);
        check_nmi(1'b1);
        check_bit("magic_map", magic_map, 1'b1);
        interrupt_edge();   // button still held while the service code already runs
        check_nmi(1'b1);
        magic_button = 1'b0;
        idle_cycles(24);
    endtask

    task automatic reentry_remap();
        logic       active;
        logic [7:0] data;
        mem_read(16'hf008, active, data);
        check_bit("magic_map", magic_map, 1'b0);
        check_bit("magic_mode", magic_mode, 1'b1);
        m1_fetch(16'h8123);
        check_bit("magic_map", magic_map, 1'b1);
        mem_read(16'h0003, active, data);
        check_bit("d_out_active", active, 1'b1);
        check_byte("d_out", data, rom_model[3]);
    endtask

    initial begin
        errors       = 0;
        checks       = 0;
        seed         = 32'h1500_a5c5;
        rst_n        = 1'b0;
        bus          = '0;
        n_int        = 1'b1;
        n_int_next   = 1'b1;
        magic_button = 1'b0;
        pause_button = 1'b0;
        sd_cd        = 1'b0;
        div_automap  = 1'b0;
        $readmemh("source/magic_rom.hex", rom_model);
        repeat (16) begin
            @(posedge clk28);
        end
        #1;
        rst_n = 1'b1;
        reset_state();
        rom_and_status_reads();
        config_writes();
        service_exit();
        nmi_entry();
        reentry_remap();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    initial begin
        #(watchdog_cycles * clk_period);
        $display("timeout after %0d cycles, the tests did not finish", watchdog_cycles);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
source/magic_pkg.sv
source/magic_input_sync.sv
source/magic_ctrl.sv
source/magic_config_regs.sv
source/magic_rom.sv
source/magic_top.sv
bench/tb_magic.sv

// File: source/magic_config_regs.sv
`default_nettype none

module magic_config_regs (
    input  wire logic                     clk28,
    input  wire logic                     rst_n,
    input  wire magic_pkg::cpu_bus_t      bus,
    input  wire logic                     magic_map,
    input  wire magic_pkg::magic_status_t status,
    output magic_pkg::magic_cfg_t         cfg,
    output logic                          rd_valid,
    output logic [7:0]                    rd_data
);

    import magic_pkg::*;

    logic config_cs;
    logic config_wr;
    logic status_rd;

    // any io port with low byte FF, the high byte picks the register
    assign config_cs = magic_map && bus.ioreq && bus.a_reg[7:0] == 8'hff;
    assign config_wr = config_cs && bus.wr;
    assign status_rd = config_cs && bus.rd && bus.a_reg[15:8] == 8'h00;

    always_ff @(posedge clk28 or negedge rst_n) begin
        if (!rst_n) begin
            cfg <= CFG_RESET;
        end else if (config_wr) begin
            case (bus.a_reg[15:8])
                8'h01: begin
                    cfg.beeper <= bus.d_reg[0];
                    cfg.reboot <= bus.d_reg[1];
                end
                8'h02: begin
                    cfg.machine <= machine_t'(bus.d_reg[2:0]);
                end
                8'h03: begin
                    cfg.turbo <= turbo_t'(bus.d_reg[2:0]);
                end
                8'h04: begin
                    cfg.panning <= panning_t'(bus.d_reg[1:0]);
                end
                8'h07: begin
                    cfg.joy_sinclair <= bus.d_reg[0];
                end
                8'h08: begin
                    cfg.ay_en <= bus.d_reg[0];
                end
                8'h09: begin
                    cfg.divmmc_en <= divmmc_t'(bus.d_reg[1:0]);
                end
                8'h0a: begin
                    cfg.ulaplus_en <= bus.d_reg[0];
                end
                8'h0b: begin
                    cfg.covox_en     <= bus.d_reg[0];
                    cfg.soundrive_en <= bus.d_reg[1];
                end
                default: begin
                    cfg <= cfg;   // unused ports are silently dropped
                end
            endcase
        end
    end

    always_ff @(posedge clk28 or negedge rst_n) begin
        if (!rst_n) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= status_rd;
        end
    end

    always_ff @(posedge clk28) begin
        if (status_rd) begin
            rd_data <= {4'b0000, status};
        end
    end

endmodule

`default_nettype wire

// File: source/magic_ctrl.sv
`default_nettype none

module magic_ctrl (
    input  wire logic                     clk28,
    input  wire logic                     rst_n,
    input  wire magic_pkg::cpu_bus_t      bus,
    input  wire logic                     n_int,
    input  wire logic                     n_int_next,
    input  wire magic_pkg::magic_status_t status,
    input  wire logic                     cfg_rd_valid,
    input  wire logic [7:0]               cfg_rd_data,
    input  wire logic                     rom_rd_valid,
    input  wire logic [7:0]               rom_rd_data,
    output logic                          n_nmi,
    output logic                          magic_mode,
    output logic                          magic_map,
    output logic [7:0]                    d_out,
    output logic                          d_out_active
);

    logic unmap_pending;
    logic reentry;
    logic trigger;
    logic exit_rd;
    logic reentry_rd;
    logic vector_fetch;

    // the frame interrupt edge is seen as n_int high with n_int_next low
    assign trigger = (status.magic_button || status.pause_button)
                   && n_int && !n_int_next;

    assign exit_rd    = magic_map && bus.memreq && bus.rd && bus.a_reg == 16'hf000;
    assign reentry_rd = magic_map && bus.memreq && bus.rd && bus.a_reg == 16'hf008;

    // after a re-entry read any m1 fetch brings the rom back, not just the nmi vector
    assign vector_fetch = magic_mode && bus.m1 && bus.memreq
                        && (bus.a_reg == 16'h0066 || reentry);

    always_ff @(posedge clk28 or negedge rst_n) begin
        if (!rst_n) begin
            n_nmi         <= 1'b1;
            magic_mode    <= 1'b1;
            magic_map     <= 1'b1;
            unmap_pending <= 1'b0;
            reentry       <= 1'b0;
        end else begin
            if (trigger) begin
                if (!magic_mode) begin
                    n_nmi <= 1'b0;   // only a fresh entry pulls the nmi line
                end
                magic_mode <= 1'b1;
            end

            // the exit read wins over the trigger above when both fall in one cycle
            if (exit_rd && !reentry) begin
                unmap_pending <= 1'b1;
                magic_mode    <= 1'b0;
            end else if (reentry_rd) begin
                unmap_pending <= 1'b1;
                reentry       <= 1'b1;
            end else if (unmap_pending && !bus.memreq) begin
                magic_map     <= 1'b0;
                unmap_pending <= 1'b0;
            end else if (vector_fetch) begin
                n_nmi     <= 1'b1;
                magic_map <= 1'b1;
                reentry   <= 1'b0;
            end
        end
    end

    // config port and rom never answer in the same cycle
    always_comb begin
        d_out_active = cfg_rd_valid || rom_rd_valid;
        if (cfg_rd_valid) begin
            d_out = cfg_rd_data;
        end else begin
            d_out = rom_rd_data;
        end
    end

endmodule

`default_nettype wire

// File: source/magic_input_sync.sv
`default_nettype none

module magic_input_sync #(
    parameter int debounce_bits = 4
) (
    input  wire logic                    clk28,
    input  wire logic                    rst_n,
    input  wire logic                    magic_button,
    input  wire logic                    pause_button,
    input  wire logic                    sd_cd,
    input  wire logic                    div_automap,
    output magic_pkg::magic_status_t     status
);

    logic [3:0] raw;
    logic [3:0] sync1;
    logic [3:0] sync2;
    logic [3:0] stable;
    logic [debounce_bits-1:0] cnt [4];

    // same order as the status struct
    assign raw = {div_automap, sd_cd, pause_button, magic_button};

    always_ff @(posedge clk28 or negedge rst_n) begin
        if (!rst_n) begin
            sync1  <= '0;
            sync2  <= '0;
            stable <= '0;
            for (int i = 0; i < 4; i++) begin
                cnt[i] <= '0;
            end
        end else begin
            sync1 <= raw;
            sync2 <= sync1;
            for (int i = 0; i < 4; i++) begin
                if (sync2[i] == stable[i]) begin
                    cnt[i] <= '0;   // any bounce back restarts the hold time
                end else if (cnt[i] == {debounce_bits{1'b1}}) begin
                    stable[i] <= sync2[i];
                    cnt[i]    <= '0;
                end else begin
                    cnt[i] <= cnt[i] + 1'b1;
                end
            end
        end
    end

    assign status = stable;

endmodule

`default_nettype wire

// File: source/magic_pkg.sv
`default_nettype none

package magic_pkg;

    // one sample of the cpu bus, acted on at the clock edge it is seen
    typedef struct packed {
        logic [15:0] a_reg;
        logic [7:0]  d_reg;
        logic        memreq;
        logic        ioreq;
        logic        rd;
        logic        wr;
        logic        m1;
    } cpu_bus_t;

    typedef enum logic [2:0] {
        MACHINE_S48  = 3'd0,
        MACHINE_S128 = 3'd1,
        MACHINE_S3   = 3'd2,
        MACHINE_PENT = 3'd3,
        MACHINE_ZX2  = 3'd4
    } machine_t;

    typedef enum logic [2:0] {
        TURBO_NONE = 3'd0,
        TURBO_X2   = 3'd1,
        TURBO_X4   = 3'd2,
        TURBO_X5   = 3'd3,
        TURBO_X8   = 3'd4
    } turbo_t;

    typedef enum logic [1:0] {
        PANNING_ABC  = 2'd0,
        PANNING_ACB  = 2'd1,
        PANNING_MONO = 2'd2
    } panning_t;

    typedef enum logic [1:0] {
        DIVMMC_OFF  = 2'd0,
        DIVMMC_ON   = 2'd1,
        DIVMMC_NOOS = 2'd2
    } divmmc_t;

    typedef struct packed {
        logic     reboot;
        logic     beeper;
        machine_t machine;
        turbo_t   turbo;
        panning_t panning;
        logic     joy_sinclair;
        divmmc_t  divmmc_en;
        logic     ulaplus_en;
        logic     ay_en;
        logic     covox_en;
        logic     soundrive_en;
    } magic_cfg_t;

    // bit order matches the read-back byte of port 00FF, magic_button in bit 0
    typedef struct packed {
        logic div_automap;
        logic sd_cd;
        logic pause_button;
        logic magic_button;
    } magic_status_t;

    localparam magic_cfg_t CFG_RESET = '{
        reboot:       1'b0,
        beeper:       1'b0,
        machine:      MACHINE_PENT,
        turbo:        TURBO_NONE,
        panning:      PANNING_ABC,
        joy_sinclair: 1'b0,
        divmmc_en:    DIVMMC_NOOS,
        ulaplus_en:   1'b1,
        ay_en:        1'b1,
        covox_en:     1'b1,
        soundrive_en: 1'b1
    };

endpackage

`default_nettype wire

// File: source/magic_rom.hex
// service rom test image, one hex byte per line from address 00 to 1F
F3
31
00
80
3E
03
01
FF
02
ED
79
3E
01
01
FF
0B
ED
79
01
FF
00
ED
78
E6
0F
20
FA
C3
00
F0
00
76

// File: source/magic_rom.sv
`default_nettype none

module magic_rom #(
    parameter int rom_abits = 5
) (
    input  wire logic                clk28,
    input  wire logic                rst_n,
    input  wire magic_pkg::cpu_bus_t bus,
    input  wire logic                magic_map,
    output logic                     rd_valid,
    output logic [7:0]               rd_data
);

    logic [7:0] mem [2**rom_abits];
    logic       rom_rd;

    initial begin
        $readmemh("source/magic_rom.hex", mem);
    end

    // the image repeats through the whole low 16 KB
    assign rom_rd = magic_map && bus.memreq && bus.rd && bus.a_reg[15:14] == 2'b00;

    always_ff @(posedge clk28 or negedge rst_n) begin
        if (!rst_n) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= rom_rd;
        end
    end

    always_ff @(posedge clk28) begin
        if (rom_rd) begin
            rd_data <= mem[bus.a_reg[rom_abits-1:0]];
        end
    end

endmodule

`default_nettype wire

// File: source/magic_top.sv
`default_nettype none

module magic_top (
    input  wire logic                clk28,
    input  wire logic                rst_n,
    input  wire magic_pkg::cpu_bus_t bus,
    input  wire logic                n_int,
    input  wire logic                n_int_next,
    input  wire logic                magic_button,
    input  wire logic                pause_button,
    input  wire logic                sd_cd,
    input  wire logic                div_automap,
    output logic [7:0]               d_out,
    output logic                     d_out_active,
    output logic                     n_nmi,
    output logic                     magic_mode,
    output logic                     magic_map,
    output magic_pkg::magic_cfg_t    cfg
);

    import magic_pkg::*;

    magic_status_t status;
    logic          cfg_rd_valid;
    logic [7:0]    cfg_rd_data;
    logic          rom_rd_valid;
    logic [7:0]    rom_rd_data;

    magic_input_sync #(
        .debounce_bits (4)   // 16 stable cycles before a change is taken
    ) u_input_sync (
        .clk28        (clk28),
        .rst_n        (rst_n),
        .magic_button (magic_button),
        .pause_button (pause_button),
        .sd_cd        (sd_cd),
        .div_automap  (div_automap),
        .status       (status)
    );

    magic_ctrl u_ctrl (
        .clk28        (clk28),
        .rst_n        (rst_n),
        .bus          (bus),
        .n_int        (n_int),
        .n_int_next   (n_int_next),
        .status       (status),
        .cfg_rd_valid (cfg_rd_valid),
        .cfg_rd_data  (cfg_rd_data),
        .rom_rd_valid (rom_rd_valid),
        .rom_rd_data  (rom_rd_data),
        .n_nmi        (n_nmi),
        .magic_mode   (magic_mode),
        .magic_map    (magic_map),
        .d_out        (d_out),
        .d_out_active (d_out_active)
    );

    magic_config_regs u_config_regs (
        .clk28     (clk28),
        .rst_n     (rst_n),
        .bus       (bus),
        .magic_map (magic_map),
        .status    (status),
        .cfg       (cfg),
        .rd_valid  (cfg_rd_valid),
        .rd_data   (cfg_rd_data)
    );

    magic_rom #(
        .rom_abits (5)
    ) u_rom (
        .clk28     (clk28),
        .rst_n     (rst_n),
        .bus       (bus),
        .magic_map (magic_map),
        .rd_valid  (rom_rd_valid),
        .rd_data   (rom_rd_data)
    );

endmodule

`default_nettype wire
